// File: dataPath.f
+incdir+verilog
verilog/aluOpsPkg.sv
verilog/busSourcePkg.sv
verilog/busArbiter.sv
verilog/registerFile.sv
verilog/aluUnit.sv
verilog/memoryDataReg.sv
verilog/dataPath.sv
verification/dataPathTb.sv

// File: runSim.sh
#!/bin/sh
# Builds the dataPath testbench with Verilator and runs it from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module dataPathTb \
    --Mdir obj_dir -o dataPathSim \
    -f dataPath.f
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/dataPathSim 2>&1)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -q "^All tests passed!$"; then
    exit 0
else
    echo "Simulation did not report a pass"
    exit 1
fi

// File: verification/dataPathTb.sv
`timescale 1ns/1ps
`include "dataPath_params.svh"

module dataPathTb
    import aluOpsPkg::*;
    import busSourcePkg::*;
();

    localparam int CLOCK_PERIOD = 4;
    localparam int RESET_CYCLES = 4;
    localparam realtime DRIVE_DELAY = 0.5;
    localparam realtime SAMPLE_DELAY = 1.0;

    logic                   Clock;
    logic                   reset;
    logic [`REG_COUNT-1:0]  regLoad;
    logic [`REG_COUNT-1:0]  regDrive;
    logic                   pcLoad, pcDrive, irLoad, irDrive;
    logic                   hiLoad, hiDrive, loLoad, loDrive;
    logic                   yLoad, zLowLoad, zHighLoad, zLowDrive, zHighDrive;
    logic                   marLoad, mdrLoad, mdrDrive, memRead;
    aluOp                   operation;
    logic [`DATA_WIDTH-1:0] memData;
    logic [`DATA_WIDTH-1:0] busData;
    logic [`DATA_WIDTH-1:0] marAddress;
    logic                   busConflict;

    int          errorCount = 0;
    int          checkCount = 0;
    int          vectorCount = 0;
    logic        vectorsReady = 1'b0;
    logic [31:0] randState = 32'h2b408291;

    logic [31:0] opWords [$];
    logic [31:0] aWords [$];
    logic [31:0] bWords [$];
    logic [31:0] lowWords [$];
    logic [31:0] highWords [$];

    dataPath dut (.*);

    always #(CLOCK_PERIOD / 2) Clock = ~Clock;

    function automatic logic [31:0] nextRandom(input logic [31:0] state);
        logic [31:0] x;
        x = state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic checkWord(input string testName, input logic [`DATA_WIDTH-1:0] expected,
                             input logic [`DATA_WIDTH-1:0] actual);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("mismatch %s: expected %h, actual %h", testName, expected, actual);
        end
    endtask

    task automatic checkSource(input string testName, input busSource expected,
                               input busSource actual);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("mismatch %s: expected %s (%0d), actual %s (%0d)", testName,
                     expected.name(), expected, actual.name(), actual);
        end
    endtask

    task automatic checkFlag(input string testName, input logic expected, input logic actual);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("mismatch %s: expected %b, actual %b", testName, expected, actual);
        end
    endtask

    task automatic idleControls();
        regLoad = '0;
        regDrive = '0;
        pcLoad = 1'b0;
        pcDrive = 1'b0;
        irLoad = 1'b0;
        irDrive = 1'b0;
        hiLoad = 1'b0;
        hiDrive = 1'b0;
        loLoad = 1'b0;
        loDrive = 1'b0;
        yLoad = 1'b0;
        zLowLoad = 1'b0;
        zHighLoad = 1'b0;
        zLowDrive = 1'b0;
        zHighDrive = 1'b0;
        marLoad = 1'b0;
        mdrLoad = 1'b0;
        mdrDrive = 1'b0;
        memRead = 1'b0;
        operation = ADD;
        memData = '0;
    endtask

    // Controls for one microstep change just after the rising edge
    task automatic nextStep();
        @(posedge Clock);
        #DRIVE_DELAY;
        idleControls();
    endtask

    task automatic memoryToMdr(input logic [`DATA_WIDTH-1:0] value);
        nextStep();
        memRead = 1'b1;
        mdrLoad = 1'b1;
        memData = value;
    endtask

    task automatic loadRegister(input int index, input logic [`DATA_WIDTH-1:0] value);
        memoryToMdr(value);
        nextStep();
        mdrDrive = 1'b1;
        regLoad[index] = 1'b1;
    endtask

    task automatic readRegister(input int index, input logic [`DATA_WIDTH-1:0] expected,
                                input string testName);
        nextStep();
        regDrive[index] = 1'b1;
        #SAMPLE_DELAY;
        checkWord(testName, expected, busData);
        checkSource(testName, busSource'(index), dut.busSelect);
    endtask

    task automatic loadSpecial(input busSource target, input logic [`DATA_WIDTH-1:0] value);
        memoryToMdr(value);
        nextStep();
        mdrDrive = 1'b1;
        case (target)
            PC: pcLoad = 1'b1;
            IR: irLoad = 1'b1;
            HI: hiLoad = 1'b1;
            LO: loLoad = 1'b1;
            default: begin
                errorCount++;
                $display("Cannot load %s from the bus in this testbench", target.name());
            end
        endcase
    endtask

    task automatic readSpecial(input busSource source, input logic [`DATA_WIDTH-1:0] expected,
                               input string testName);
        nextStep();
        case (source)
            PC: pcDrive = 1'b1;
            IR: irDrive = 1'b1;
            HI: hiDrive = 1'b1;
            LO: loDrive = 1'b1;
            ZLOW: zLowDrive = 1'b1;
            ZHIGH: zHighDrive = 1'b1;
            default: mdrDrive = 1'b1;
        endcase
        #SAMPLE_DELAY;
        checkWord(testName, expected, busData);
        checkSource(testName, source, dut.busSelect);
    endtask

    // A into Y, then B on the bus with the operation, then read both Z halves
    task automatic runAluVector(input int k);
        aluOp  op;
        string testName;
        op = aluOp'(opWords[k][4:0]);
        testName = $sformatf("vector %0d %s", k, op.name());
        memoryToMdr(aWords[k]);
        nextStep();
        mdrDrive = 1'b1;
        yLoad = 1'b1;
        memoryToMdr(bWords[k]);
        nextStep();
        mdrDrive = 1'b1;
        operation = op;
        zLowLoad = 1'b1;
        zHighLoad = 1'b1;
        readSpecial(ZLOW, lowWords[k], {testName, " low"});
        readSpecial(ZHIGH, highWords[k], {testName, " high"});
    endtask

    task automatic incrementPc(input logic [`DATA_WIDTH-1:0] start);
        logic [`DATA_WIDTH-1:0] expected;
        expected = start + 1'b1;
        loadSpecial(PC, start);
        nextStep();
        pcDrive = 1'b1;
        operation = INC;
        zLowLoad = 1'b1;
        nextStep();
        zLowDrive = 1'b1;
        pcLoad = 1'b1;
        nextStep();
        pcDrive = 1'b1;
        marLoad = 1'b1;
        #SAMPLE_DELAY;
        checkWord($sformatf("pc increment from %h", start), expected, busData);
        nextStep();
        #SAMPLE_DELAY;
        checkWord($sformatf("mar after pc %h", start), expected, marAddress);
    endtask

    task automatic driveConflict();
        nextStep();
        $assertoff;  // Two drivers on purpose
        regDrive = 16'h0005;
        nextStep();
        $asserton;
        #SAMPLE_DELAY;
        checkFlag("conflict raised", 1'b1, busConflict);
        nextStep();
        regDrive[3] = 1'b1;
        nextStep();
        #SAMPLE_DELAY;
        checkFlag("single driver no conflict", 1'b0, busConflict);
    endtask

    task automatic readVectors();
        int          fd;
        int          fields;
        string       line;
        logic [31:0] opCode, aVal, bVal, lowVal, highVal;
        fd = $fopen("verification/dataPathTestdata.txt", "r");
        if (fd == 0) begin
            errorCount++;
            $display("Could not open the test data file");
        end else begin
            while ($fgets(line, fd) != 0) begin
                fields = $sscanf(line, "%h %h %h %h %h", opCode, aVal, bVal, lowVal, highVal);
                if (fields == 5) begin  // Comment and blank lines fall through
                    opWords.push_back(opCode);
                    aWords.push_back(aVal);
                    bWords.push_back(bVal);
                    lowWords.push_back(lowVal);
                    highWords.push_back(highVal);
                end
            end
            $fclose(fd);
            if (opWords.size() == 0) begin
                errorCount++;
                $display("The test data file holds no vectors");
            end
        end
        vectorCount = opWords.size();
    endtask

    initial begin : watchdog
        wait (vectorsReady);
        #((vectorCount * 8 + 200) * CLOCK_PERIOD);
        $display("Timeout after %0d cycles, the test sequence did not finish",
                 vectorCount * 8 + 200);
        $display("Test failures found");
        $finish;
    end

    initial begin : mainSequence
        logic [`DATA_WIDTH-1:0] regValues [`REG_COUNT];
        logic [`DATA_WIDTH-1:0] specialValues [4];
        busSource               specials [4];
        Clock = 1'b0;
        reset = 1'b1;
        idleControls();
        specials = '{PC, IR, HI, LO};
        readVectors();
        vectorsReady = 1'b1;

        repeat (RESET_CYCLES) @(posedge Clock);
        #DRIVE_DELAY;
        reset = 1'b0;

        // Reset state
        nextStep();
        #SAMPLE_DELAY;
        checkWord("idle bus after reset", '0, busData);
        checkFlag("no conflict after reset", 1'b0, busConflict);
        checkSource("idle select after reset", NONE, dut.busSelect);
        for (int i = 0; i < `REG_COUNT; i++) begin
            readRegister(i, '0, $sformatf("R%0d after reset", i));
        end

        for (int i = 0; i < `REG_COUNT; i++) begin
            randState = nextRandom(randState);
            regValues[i] = randState;
            loadRegister(i, regValues[i]);
        end
        for (int i = 0; i < `REG_COUNT; i++) begin
            readRegister(i, regValues[i], $sformatf("R%0d readback", i));
        end

        for (int i = 0; i < 4; i++) begin
            randState = nextRandom(randState);
            specialValues[i] = randState;
            loadSpecial(specials[i], specialValues[i]);
        end
        for (int i = 0; i < 4; i++) begin
            readSpecial(specials[i], specialValues[i],
                        $sformatf("%s readback", specials[i].name()));
        end

        for (int k = 0; k < vectorCount; k++) begin
            runAluVector(k);
        end

        incrementPc(specialValues[0]);
        incrementPc(32'hffffffff);  // Wraps to zero

        driveConflict();

        nextStep();
        $display("Checks run: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// File: verification/dataPathTestdata.txt
// ALU vectors, all hex: op operandA operandB expectedLow expectedHigh
// Op codes: 0 ADD 1 SUB 2 AND 3 OR 4 SHR 5 SHL 6 ROR 7 ROL 8 NEG 9 NOT a MUL b INC
00 00000005 00000003 00000008 00000000
00 ffffffff 00000002 00000001 00000000
01 00000010 00000003 0000000d 00000000
01 00000003 00000005 fffffffe 00000000
02 f0f0a5a5 0ff0ffff 00f0a5a5 00000000
03 12340000 00005678 12345678 00000000
04 80000000 00000004 08000000 00000000
04 12345678 00000024 01234567 00000000
05 00000001 0000001f 80000000 00000000
05 12345678 00000008 34567800 00000000
06 12345678 00000004 81234567 00000000
07 12345678 00000008 34567812 00000000
08 deadbeef 00000001 ffffffff 00000000
09 00000000 0f0f0f0f f0f0f0f0 00000000
0a 00010000 00010000 00000000 00000001
0a ffffffff ffffffff 00000001 fffffffe
0a 00000007 00000006 0000002a 00000000
0b 12345678 0000ffff 00010000 00000000

// File: verilog/aluOpsPkg.sv
package aluOpsPkg;

    // ALU operation codes applied to Y and the bus word
    typedef enum logic [4:0] {
        ADD = 5'd0,
        SUB = 5'd1,
        AND = 5'd2,
        OR  = 5'd3,
        SHR = 5'd4,   // Logical right shift of Y
        SHL = 5'd5,
        ROR = 5'd6,
        ROL = 5'd7,
        NEG = 5'd8,   // Two's complement of the bus word
        NOT = 5'd9,
        MUL = 5'd10,  // Full 64 bit unsigned product
        INC = 5'd11   // Bus word plus one for the PC increment
    } aluOp;

endpackage

// File: verilog/aluUnit.sv
`timescale 1ns/1ps
`include "dataPath_params.svh"

module aluUnit
    import aluOpsPkg::*;
(
    input  logic [`DATA_WIDTH-1:0]   yWord,
    input  logic [`DATA_WIDTH-1:0]   busData,
    input  aluOp                     operation,
    output logic [2*`DATA_WIDTH-1:0] result
);

    localparam int SHIFT_BITS = $clog2(`DATA_WIDTH);

    logic [SHIFT_BITS-1:0]    shiftAmount;
    logic [2*`DATA_WIDTH-1:0] doubled;
    logic [2*`DATA_WIDTH-1:0] rightRotated;
    logic [2*`DATA_WIDTH-1:0] leftRotated;
    logic [2*`DATA_WIDTH-1:0] product;
    logic [`DATA_WIDTH-1:0]   lowWord;

    assign shiftAmount = busData[SHIFT_BITS-1:0];  // Low bits of the bus give the amount

    // Two copies of Y side by side turn a rotate into a plain shift
    assign doubled = {yWord, yWord};
    assign rightRotated = doubled >> shiftAmount;
    assign leftRotated = doubled << shiftAmount;

    assign product = {{`DATA_WIDTH{1'b0}}, yWord} * {{`DATA_WIDTH{1'b0}}, busData};

    always_comb begin
        case (operation)
            ADD: lowWord = yWord + busData;
            SUB: lowWord = yWord - busData;
            AND: lowWord = yWord & busData;
            OR:  lowWord = yWord | busData;
            SHR: lowWord = yWord >> shiftAmount;
            SHL: lowWord = yWord << shiftAmount;
            ROR: lowWord = rightRotated[`DATA_WIDTH-1:0];
            ROL: lowWord = leftRotated[2*`DATA_WIDTH-1:`DATA_WIDTH];
            NEG: lowWord = -busData;
            NOT: lowWord = ~busData;
            MUL: lowWord = product[`DATA_WIDTH-1:0];
            INC: lowWord = busData + 1'b1;
            default: lowWord = '0;
        endcase
    end

    // Only the multiply fills the upper half
    always_comb begin
        if (operation == MUL) begin
            result = product;
        end else begin
            result = {{`DATA_WIDTH{1'b0}}, lowWord};
        end
    end

endmodule

// File: verilog/busArbiter.sv
`timescale 1ns/1ps
`include "dataPath_params.svh"

module busArbiter
    import busSourcePkg::*;
(
    input  logic                   Clock,
    input  logic                   reset,
    input  logic [DRIVER_COUNT-1:0] driveEnables,
    input  logic [`DATA_WIDTH-1:0] sources [DRIVER_COUNT],
    output logic [`DATA_WIDTH-1:0] busData,
    output busSource               selected,
    output logic                   busConflict
);

    logic [`SEL_WIDTH-1:0]  code;
    logic [`DATA_WIDTH-1:0] merged;
    logic                   multiDrive;

    // OR together the index and word of every enabled source
    // With a single driver this is an exact encoder and mux
    always_comb begin
        code = '0;
        merged = '0;
        for (int i = 0; i < DRIVER_COUNT; i++) begin
            if (driveEnables[i]) begin
                code = code | `SEL_WIDTH'(i);
                merged = merged | sources[i];
            end
        end
    end

    assign selected = (driveEnables == '0) ? NONE : busSource'(code);
    assign busData = merged;  // Zero when nothing drives

    assign multiDrive = ($countones(driveEnables) > 1);

    always_ff @(posedge Clock) begin
        if (reset) begin
            busConflict <= 1'b0;
        end else begin
            busConflict <= multiDrive;  // Flag shows in the cycle after the clash
        end
    end

    // The control sequence never enables two drivers at once
    singleDriver: assert property (
        @(posedge Clock) disable iff (reset)
        $onehot0(driveEnables)
    ) else $error("busArbiter: more than one bus driver enabled");

endmodule

// File: verilog/busSourcePkg.sv
`include "dataPath_params.svh"

package busSourcePkg;

    // Bus drivers in drive enable bit order
    typedef enum logic [`SEL_WIDTH-1:0] {
        R0, R1, R2, R3,
        R4, R5, R6, R7,
        R8, R9, R10, R11,
        R12, R13, R14, R15,
        PC,
        IR,
        HI,
        LO,
        ZLOW,
        ZHIGH,
        MDR,
        NONE  // Bus reads zero when no driver is enabled
    } busSource;

    // One drive enable per real source
    localparam int DRIVER_COUNT = int'(NONE);

endpackage

// File: verilog/dataPath.sv
`timescale 1ns/1ps
`include "dataPath_params.svh"

module dataPath
    import aluOpsPkg::*;
    import busSourcePkg::*;
(
    input  logic                   Clock,
    input  logic                   reset,
    input  logic [`REG_COUNT-1:0]  regLoad,
    input  logic [`REG_COUNT-1:0]  regDrive,
    input  logic                   pcLoad,
    input  logic                   pcDrive,
    input  logic                   irLoad,
    input  logic                   irDrive,
    input  logic                   hiLoad,
    input  logic                   hiDrive,
    input  logic                   loLoad,
    input  logic                   loDrive,
    input  logic                   yLoad,
    input  logic                   zLowLoad,
    input  logic                   zHighLoad,
    input  logic                   zLowDrive,
    input  logic                   zHighDrive,
    input  logic                   marLoad,
    input  logic                   mdrLoad,
    input  logic                   mdrDrive,
    input  logic                   memRead,
    input  aluOp                   operation,
    input  logic [`DATA_WIDTH-1:0] memData,
    output logic [`DATA_WIDTH-1:0] busData,
    output logic [`DATA_WIDTH-1:0] marAddress,
    output logic                   busConflict
);

    logic [`DATA_WIDTH-1:0]   regWords [`REG_COUNT];
    logic [`DATA_WIDTH-1:0]   pcWord, irWord, hiWord, loWord;
    logic [`DATA_WIDTH-1:0]   yWord, zLowWord, zHighWord, marWord, mdrWord;
    logic [2*`DATA_WIDTH-1:0] aluResult;
    logic [DRIVER_COUNT-1:0]  driveEnables;
    logic [`DATA_WIDTH-1:0]   sources [DRIVER_COUNT];
    busSource                 busSelect;

    // Bit order follows the busSource encoding
    assign driveEnables = {mdrDrive, zHighDrive, zLowDrive, loDrive,
                           hiDrive, irDrive, pcDrive, regDrive};

    always_comb begin
        for (int i = 0; i < `REG_COUNT; i++) begin
            sources[i] = regWords[i];
        end
        sources[PC] = pcWord;
        sources[IR] = irWord;
        sources[HI] = hiWord;
        sources[LO] = loWord;
        sources[ZLOW] = zLowWord;
        sources[ZHIGH] = zHighWord;
        sources[MDR] = mdrWord;
    end

    busArbiter arbiter (
        .Clock(Clock), .reset(reset), .driveEnables(driveEnables), .sources(sources),
        .busData(busData), .selected(busSelect), .busConflict(busConflict)
    );

    registerFile generalRegs (
        .Clock(Clock), .reset(reset), .regLoad(regLoad), .busData(busData),
        .regWords(regWords)
    );

    aluUnit alu (.yWord(yWord), .busData(busData), .operation(operation), .result(aluResult));

    memoryDataReg mdr (
        .Clock(Clock), .reset(reset), .mdrLoad(mdrLoad), .memRead(memRead),
        .memData(memData), .busData(busData), .mdrWord(mdrWord)
    );

    // Special registers that each load from the bus on their own enable
    always_ff @(posedge Clock) begin
        if (reset) begin
            pcWord <= '0;
            irWord <= '0;
            hiWord <= '0;
            loWord <= '0;
            yWord <= '0;
            zLowWord <= '0;
            zHighWord <= '0;
            marWord <= '0;
        end else begin
            if (pcLoad) pcWord <= busData;
            if (irLoad) irWord <= busData;
            if (hiLoad) hiWord <= busData;
            if (loLoad) loWord <= busData;
            if (yLoad) yWord <= busData;
            if (zLowLoad) zLowWord <= aluResult[`DATA_WIDTH-1:0];  // Z takes the ALU, not the bus
            if (zHighLoad) zHighWord <= aluResult[2*`DATA_WIDTH-1:`DATA_WIDTH];
            if (marLoad) marWord <= busData;
        end
    end

    assign marAddress = marWord;

endmodule

// File: verilog/dataPath_params.svh
`ifndef DATAPATH_PARAMS_SVH
`define DATAPATH_PARAMS_SVH

// Width of the shared bus and of every register on it
`define DATA_WIDTH 32

// General purpose registers R0 through R15
`define REG_COUNT 16

// Bus source select wide enough for every driver plus the idle code
`define SEL_WIDTH 5

`endif

// File: verilog/memoryDataReg.sv
`timescale 1ns/1ps
`include "dataPath_params.svh"

module memoryDataReg (
    input  logic                   Clock,
    input  logic                   reset,
    input  logic                   mdrLoad,
    input  logic                   memRead,
    input  logic [`DATA_WIDTH-1:0] memData,
    input  logic [`DATA_WIDTH-1:0] busData,
    output logic [`DATA_WIDTH-1:0] mdrWord
);

    logic [`DATA_WIDTH-1:0] nextWord;

    assign nextWord = memRead ? memData : busData;  // Memory side wins on a read

    always_ff @(posedge Clock) begin
        if (reset) begin
            mdrWord <= '0;
        end else if (mdrLoad) begin
            mdrWord <= nextWord;
        end
    end

endmodule

// File: verilog/registerFile.sv
`timescale 1ns/1ps
`include "dataPath_params.svh"

module registerFile (
    input  logic                   Clock,
    input  logic                   reset,
    input  logic [`REG_COUNT-1:0]  regLoad,
    input  logic [`DATA_WIDTH-1:0] busData,
    output logic [`DATA_WIDTH-1:0] regWords [`REG_COUNT]
);

    logic [`DATA_WIDTH-1:0] words [`REG_COUNT];

    // Every register listens to the same bus word
    always_ff @(posedge Clock) begin
        if (reset) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                words[i] <= '0;
            end
        end else begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                if (regLoad[i]) begin
                    words[i] <= busData;
                end
            end
        end
    end

    always_comb begin
        for (int i = 0; i < `REG_COUNT; i++) begin
            regWords[i] = words[i];
        end
    end

    // One bus transfer per cycle means one destination register
    singleLoad: assert property (
        @(posedge Clock) disable iff (reset)
        $onehot0(regLoad)
    ) else $error("registerFile: more than one register load enabled");

endmodule
